/* logic/uce.sv */
`timescale 1ns/1ps
`default_nettype none

module uce
  import uce_pkg::*;
  #(
    parameter int credits_p = 4
  )
  (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic [lce_id_width_c-1:0] lce_id_i,
    input  cache_req_t                cache_req_i,
    input  logic                      cache_req_v_i,
    output logic                      cache_req_yumi_o,
    input  cache_metadata_t           cache_metadata_i,
    input  logic                      cache_metadata_v_i,
    output tag_pkt_t                  tag_pkt_o,
    output logic                      tag_pkt_v_o,
    input  logic                      tag_pkt_yumi_i,
    output stat_pkt_t                 stat_pkt_o,
    output logic                      stat_pkt_v_o,
    input  logic                      stat_pkt_yumi_i,
    output data_pkt_t                 data_pkt_o,
    output logic                      data_pkt_v_o,
    input  logic                      data_pkt_yumi_i,
    output mem_hdr_t                  mem_cmd_hdr_o,
    output logic [block_width_c-1:0]  mem_cmd_data_o,
    output logic                      mem_cmd_v_o,
    input  logic                      mem_cmd_ready_and_i,
    input  mem_hdr_t                  mem_resp_hdr_i,
    input  logic [block_width_c-1:0]  mem_resp_data_i,
    input  logic                      mem_resp_v_i,
    output logic                      mem_resp_ready_and_o,
    output logic                      cache_req_busy_o,
    output logic                      cache_req_complete_o,
    output logic                      cache_req_critical_tag_o,
    output logic                      cache_req_critical_data_o,
    output logic                      cache_req_credits_full_o,
    output logic                      cache_req_credits_empty_o
  );

  cache_req_t req;
  logic req_v;
  cache_metadata_t metadata;
  logic metadata_v;
  req_class_t req_class;
  logic cmd_sent;
  logic resp_taken;

  assign cmd_sent   = mem_cmd_v_o & mem_cmd_ready_and_i;
  assign resp_taken = mem_resp_v_i & mem_resp_ready_and_o;

  uce_req_capture req_capture
  (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .cache_req_i        (cache_req_i),
    .cache_req_yumi_i   (cache_req_yumi_o),
    .cache_metadata_i   (cache_metadata_i),
    .cache_metadata_v_i (cache_metadata_v_i),
    .req_complete_i     (cache_req_complete_o),
    .req_o              (req),
    .req_v_o            (req_v),
    .metadata_o         (metadata),
    .metadata_v_o       (metadata_v),
    .req_class_o        (req_class)
  );

  uce_credit_tracker #(.credits_p(credits_p)) credit_tracker
  (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_sent_i      (cmd_sent),
    .resp_taken_i    (resp_taken),
    .credits_full_o  (cache_req_credits_full_o),
    .credits_empty_o (cache_req_credits_empty_o)
  );

  uce_fsm fsm
  (
    .clk_i                     (clk_i),
    .reset_i                   (reset_i),
    .lce_id_i                  (lce_id_i),
    .cache_req_v_i             (cache_req_v_i),
    .cache_req_type_i          (cache_req_i.req_type),
    .cache_req_yumi_o          (cache_req_yumi_o),
    .cache_req_busy_o          (cache_req_busy_o),
    .cache_req_complete_o      (cache_req_complete_o),
    .cache_req_critical_tag_o  (cache_req_critical_tag_o),
    .cache_req_critical_data_o (cache_req_critical_data_o),
    .req_i                     (req),
    .req_v_i                   (req_v),
    .metadata_i                (metadata),
    .metadata_v_i              (metadata_v),
    .req_class_i               (req_class),
    .credits_full_i            (cache_req_credits_full_o),
    .tag_pkt_o                 (tag_pkt_o),
    .tag_pkt_v_o               (tag_pkt_v_o),
    .tag_pkt_yumi_i            (tag_pkt_yumi_i),
    .stat_pkt_o                (stat_pkt_o),
    .stat_pkt_v_o              (stat_pkt_v_o),
    .stat_pkt_yumi_i           (stat_pkt_yumi_i),
    .data_pkt_o                (data_pkt_o),
    .data_pkt_v_o              (data_pkt_v_o),
    .data_pkt_yumi_i           (data_pkt_yumi_i),
    .mem_cmd_hdr_o             (mem_cmd_hdr_o),
    .mem_cmd_data_o            (mem_cmd_data_o),
    .mem_cmd_v_o               (mem_cmd_v_o),
    .mem_cmd_ready_and_i       (mem_cmd_ready_and_i),
    .mem_resp_hdr_i            (mem_resp_hdr_i),
    .mem_resp_data_i           (mem_resp_data_i),
    .mem_resp_v_i              (mem_resp_v_i),
    .mem_resp_ready_and_o      (mem_resp_ready_and_o)
  );

endmodule

`default_nettype wire

/* logic/uce_credit_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module uce_credit_tracker
  #(
    parameter int credits_p = 4
  )
  (
    input  logic clk_i,
    input  logic reset_i,
    input  logic cmd_sent_i,
    input  logic resp_taken_i,
    output logic credits_full_o,
    output logic credits_empty_o
  );

  localparam int count_width = $clog2(credits_p + 1);

  logic [count_width-1:0] count_r;
  logic inc;
  logic dec;

  assign inc = cmd_sent_i & ~credits_full_o;
  assign dec = resp_taken_i & ~credits_empty_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      count_r <= '0;
    else if (inc & ~dec)
      count_r <= count_r + 1'b1;
    else if (dec & ~inc)
      count_r <= count_r - 1'b1;
  end

  assign credits_full_o  = (count_r == count_width'(credits_p));
  assign credits_empty_o = (count_r == '0);

endmodule

`default_nettype wire

/* logic/uce_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module uce_fsm
  import uce_pkg::*;
  (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic [lce_id_width_c-1:0] lce_id_i,
    input  logic                      cache_req_v_i,
    input  cache_req_type_e           cache_req_type_i,
    output logic                      cache_req_yumi_o,
    output logic                      cache_req_busy_o,
    output logic                      cache_req_complete_o,
    output logic                      cache_req_critical_tag_o,
    output logic                      cache_req_critical_data_o,
    input  cache_req_t                req_i,
    input  logic                      req_v_i,
    input  cache_metadata_t           metadata_i,
    input  logic                      metadata_v_i,
    input  req_class_t                req_class_i,
    input  logic                      credits_full_i,
    output tag_pkt_t                  tag_pkt_o,
    output logic                      tag_pkt_v_o,
    input  logic                      tag_pkt_yumi_i,
    output stat_pkt_t                 stat_pkt_o,
    output logic                      stat_pkt_v_o,
    input  logic                      stat_pkt_yumi_i,
    output data_pkt_t                 data_pkt_o,
    output logic                      data_pkt_v_o,
    input  logic                      data_pkt_yumi_i,
    output mem_hdr_t                  mem_cmd_hdr_o,
    output logic [block_width_c-1:0]  mem_cmd_data_o,
    output logic                      mem_cmd_v_o,
    input  logic                      mem_cmd_ready_and_i,
    input  mem_hdr_t                  mem_resp_hdr_i,
    input  logic [block_width_c-1:0]  mem_resp_data_i,
    input  logic                      mem_resp_v_i,
    output logic                      mem_resp_ready_and_o
  );

  localparam int dwords_per_block = block_width_c / dword_width_c;

  typedef enum logic [2:0] {
    e_reset, e_clear, e_ready, e_send, e_read_wait, e_uc_read_wait
  } state_e;

  state_e state_r;
  state_e state_n;

  logic [index_width_c-1:0] index_r;
  logic index_up;
  logic index_last;
  logic critical_pending_r;
  logic load_ready;
  logic read_resp_v;
  logic write_resp;
  logic read_taken;
  logic read_cmd_sent;
  logic [index_width_c-1:0] fill_index;
  logic [tag_width_c-1:0] fill_tag;

  assign index_last = (index_r == index_width_c'(sets_c - 1));

  assign fill_index = mem_resp_hdr_i.addr[block_offset_width_c +: index_width_c];
  assign fill_tag   = mem_resp_hdr_i.addr[block_offset_width_c + index_width_c +: tag_width_c];

  assign write_resp  = mem_resp_hdr_i.msg_type inside {e_mem_wr, e_mem_uc_wr};
  assign read_resp_v = mem_resp_v_i & (mem_resp_hdr_i.msg_type inside {e_mem_rd, e_mem_uc_rd});
  assign read_taken  = read_resp_v & load_ready;

  // Store acks drain whenever they arrive
  assign mem_resp_ready_and_o = write_resp | load_ready;

  assign read_cmd_sent = (state_r == e_send) & mem_cmd_v_o & mem_cmd_ready_and_i
                         & (req_class_i.miss | req_class_i.uc_load);

  assign cache_req_busy_o = (state_r == e_reset) | (state_r == e_clear) | credits_full_i;
  assign cache_req_critical_tag_o = tag_pkt_v_o & tag_pkt_yumi_i & (tag_pkt_o.opcode == e_tag_set_tag);
  assign cache_req_critical_data_o = critical_pending_r & read_taken;

  always_comb
  begin
    state_n = state_r;
    cache_req_yumi_o = 1'b0;
    cache_req_complete_o = 1'b0;
    index_up = 1'b0;
    load_ready = 1'b0;
    tag_pkt_o = '0;
    tag_pkt_v_o = 1'b0;
    stat_pkt_o = '0;
    stat_pkt_v_o = 1'b0;
    data_pkt_o = '0;
    data_pkt_v_o = 1'b0;
    mem_cmd_hdr_o = '0;
    mem_cmd_data_o = '0;
    mem_cmd_v_o = 1'b0;

    unique case (state_r)
      e_reset:
      begin
        state_n = e_clear;
      end
      e_clear:
      begin
        tag_pkt_o.opcode = e_tag_clear_set;
        tag_pkt_o.index = index_r;
        tag_pkt_v_o = 1'b1;
        stat_pkt_o.opcode = e_stat_clear_set;
        stat_pkt_o.index = index_r;
        stat_pkt_v_o = 1'b1;
        index_up = tag_pkt_yumi_i & stat_pkt_yumi_i;
        cache_req_complete_o = index_up & index_last;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      e_ready:
      begin
        cache_req_yumi_o = cache_req_v_i & ~req_v_i;
        if (cache_req_yumi_o)
          state_n = (cache_req_type_i == e_cache_clear) ? e_clear : e_send;
      end
      e_send:
      begin
        mem_cmd_hdr_o.lce_id = lce_id_i;
        if (req_class_i.miss)
        begin
          mem_cmd_hdr_o.msg_type = e_mem_rd;
          mem_cmd_hdr_o.addr = {req_i.addr[paddr_width_c-1:block_offset_width_c],
                                {block_offset_width_c{1'b0}}};
          mem_cmd_hdr_o.size = e_size_16;
          mem_cmd_hdr_o.way_id = metadata_i.hit_or_repl_way;
          mem_cmd_v_o = metadata_v_i & ~credits_full_i;
        end
        else
        begin
          mem_cmd_hdr_o.msg_type = req_class_i.uc_load ? e_mem_uc_rd : e_mem_uc_wr;
          mem_cmd_hdr_o.addr = req_i.addr;
          mem_cmd_hdr_o.size = req_i.size;
          mem_cmd_data_o = {dwords_per_block{req_i.data}};
          mem_cmd_v_o = req_v_i & ~credits_full_i;
        end
        if (mem_cmd_v_o & mem_cmd_ready_and_i)
        begin
          cache_req_complete_o = req_class_i.uc_store;
          state_n = req_class_i.miss ? e_read_wait
                  : req_class_i.uc_load ? e_uc_read_wait : e_ready;
        end
      end
      e_read_wait:
      begin
        tag_pkt_o.opcode = e_tag_set_tag;
        tag_pkt_o.index = fill_index;
        tag_pkt_o.way_id = mem_resp_hdr_i.way_id;
        tag_pkt_o.state = e_coh_m;
        tag_pkt_o.tag = fill_tag;
        tag_pkt_v_o = read_resp_v;
        data_pkt_o.opcode = e_data_write;
        data_pkt_o.index = fill_index;
        data_pkt_o.way_id = mem_resp_hdr_i.way_id;
        data_pkt_o.data = mem_resp_data_i;
        data_pkt_v_o = read_resp_v;
        load_ready = read_resp_v & tag_pkt_yumi_i & data_pkt_yumi_i;
        cache_req_complete_o = load_ready;
        if (load_ready)
          state_n = e_ready;
      end
      e_uc_read_wait:
      begin
        data_pkt_o.opcode = e_data_uncached;
        data_pkt_o.data = {dwords_per_block{mem_resp_data_i[dword_width_c-1:0]}};
        data_pkt_v_o = read_resp_v;
        load_ready = read_resp_v & data_pkt_yumi_i;
        cache_req_complete_o = load_ready;
        if (load_ready)
          state_n = e_ready;
      end
      default:
      begin
        state_n = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_reset;
    else
      state_r <= state_n;
  end

  // Wraps to zero so that a later clear request sweeps from the first set
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      index_r <= '0;
    else if (index_up)
      index_r <= index_last ? '0 : index_r + 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      critical_pending_r <= 1'b0;
    else if (read_cmd_sent)
      critical_pending_r <= 1'b1;
    else if (read_taken)
      critical_pending_r <= 1'b0;
  end

endmodule

`default_nettype wire

/* logic/uce_pkg.sv */
`default_nettype none

package uce_pkg;

  localparam int paddr_width_c = 32;
  localparam int dword_width_c = 64;
  localparam int block_width_c = 128;
  localparam int assoc_c = 2;
  localparam int sets_c = 16;
  localparam int way_width_c = $clog2(assoc_c);
  localparam int index_width_c = $clog2(sets_c);
  localparam int block_offset_width_c = $clog2(block_width_c / 8);
  localparam int tag_width_c = paddr_width_c - index_width_c - block_offset_width_c;
  localparam int lce_id_width_c = 4;

  typedef enum logic [1:0] {e_miss_load, e_uc_load, e_uc_store, e_cache_clear} cache_req_type_e;

  typedef enum logic [1:0] {e_mem_rd, e_mem_wr, e_mem_uc_rd, e_mem_uc_wr} mem_msg_type_e;

  // Log2 of the byte count, a full block is e_size_16
  typedef enum logic [2:0] {
    e_size_1, e_size_2, e_size_4, e_size_8, e_size_16, e_size_32, e_size_64, e_size_128
  } size_e;

  typedef enum logic {e_tag_clear_set, e_tag_set_tag} tag_op_e;

  typedef enum logic {e_stat_clear_set} stat_op_e;

  typedef enum logic {e_data_write, e_data_uncached} data_op_e;

  typedef enum logic [1:0] {e_coh_i, e_coh_s, e_coh_e, e_coh_m} coh_state_e;

  typedef struct packed {
    cache_req_type_e            req_type;
    logic [paddr_width_c-1:0]   addr;
    size_e                      size;
    logic [dword_width_c-1:0]   data;
  } cache_req_t;

  typedef struct packed {
    logic [way_width_c-1:0] hit_or_repl_way;
  } cache_metadata_t;

  typedef struct packed {
    logic miss;
    logic uc_load;
    logic uc_store;
  } req_class_t;

  typedef struct packed {
    tag_op_e                    opcode;
    logic [index_width_c-1:0]   index;
    logic [way_width_c-1:0]     way_id;
    coh_state_e                 state;
    logic [tag_width_c-1:0]     tag;
  } tag_pkt_t;

  typedef struct packed {
    stat_op_e                   opcode;
    logic [index_width_c-1:0]   index;
  } stat_pkt_t;

  typedef struct packed {
    data_op_e                   opcode;
    logic [index_width_c-1:0]   index;
    logic [way_width_c-1:0]     way_id;
    logic [block_width_c-1:0]   data;
  } data_pkt_t;

  // The way travels with the read so the fill lands where the cache chose
  typedef struct packed {
    mem_msg_type_e              msg_type;
    logic [paddr_width_c-1:0]   addr;
    size_e                      size;
    logic [lce_id_width_c-1:0]  lce_id;
    logic [way_width_c-1:0]     way_id;
  } mem_hdr_t;

endpackage

`default_nettype wire

/* logic/uce_req_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module uce_req_capture
  import uce_pkg::*;
  (
    input  logic            clk_i,
    input  logic            reset_i,
    input  cache_req_t      cache_req_i,
    input  logic            cache_req_yumi_i,
    input  cache_metadata_t cache_metadata_i,
    input  logic            cache_metadata_v_i,
    input  logic            req_complete_i,
    output cache_req_t      req_o,
    output logic            req_v_o,
    output cache_metadata_t metadata_o,
    output logic            metadata_v_o,
    output req_class_t      req_class_o
  );

  always_ff @(posedge clk_i)
  begin
    if (cache_req_yumi_i)
      req_o <= cache_req_i;
    if (cache_metadata_v_i)
      metadata_o <= cache_metadata_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      req_v_o <= 1'b0;
    else if (cache_req_yumi_i)
      req_v_o <= 1'b1;
    else if (req_complete_i)
      req_v_o <= 1'b0;
  end

  // Metadata may be strobed in the acceptance cycle, so a strobe beats the clear
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      metadata_v_o <= 1'b0;
    else if (cache_metadata_v_i)
      metadata_v_o <= 1'b1;
    else if (cache_req_yumi_i)
      metadata_v_o <= 1'b0;
  end

  assign req_class_o.miss     = req_v_o & (req_o.req_type == e_miss_load);
  assign req_class_o.uc_load  = req_v_o & (req_o.req_type == e_uc_load);
  assign req_class_o.uc_store = req_v_o & (req_o.req_type == e_uc_store);

endmodule

`default_nettype wire

/* src.f */
logic/uce_pkg.sv
logic/uce_req_capture.sv
logic/uce_credit_tracker.sv
logic/uce_fsm.sv
logic/uce.sv
testbench/tb_mem_responder.sv
testbench/tb_uce.sv

/* testbench/tb_mem_responder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_responder
  import uce_pkg::*;
  (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     hold_i,
    input  mem_hdr_t                 cmd_hdr_i,
    input  logic [block_width_c-1:0] cmd_data_i,
    input  logic                     cmd_v_i,
    output logic                     cmd_ready_and_o,
    output mem_hdr_t                 resp_hdr_o,
    output logic [block_width_c-1:0] resp_data_o,
    output logic                     resp_v_o,
    input  logic                     resp_ready_and_i
  );

  // Backing store of 64 blocks, indexed by address bits 9:4
  logic [block_width_c-1:0] store [0:63];
  mem_hdr_t pend_q [$];
  int delay;
  logic [5:0] blk;
  logic [dword_width_c-1:0] dword;

  assign cmd_ready_and_o = 1'b1;

  initial
  begin
    resp_v_o = 1'b0;
    resp_hdr_o = '0;
    resp_data_o = '0;
    delay = 0;
  end

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < 64; i++)
        store[i] = {$urandom, $urandom, $urandom, $urandom};
      pend_q.delete();
      delay = 0;
      resp_v_o <= 1'b0;
    end
    else
    begin
      if (cmd_v_i && cmd_hdr_i.msg_type == e_mem_uc_wr)
      begin
        blk = cmd_hdr_i.addr[9:4];
        store[blk][cmd_hdr_i.addr[3]*dword_width_c +: dword_width_c] =
          cmd_data_i[dword_width_c-1:0];
      end
      if (cmd_v_i)
        pend_q.push_back(cmd_hdr_i);
      if (resp_v_o && resp_ready_and_i)
      begin
        resp_v_o <= 1'b0;
        void'(pend_q.pop_front());
        delay = $urandom_range(0, 3);
      end
      else if (!resp_v_o && !hold_i && pend_q.size() != 0)
      begin
        if (delay > 0)
          delay--;
        else
        begin
          // Uncached reads return the addressed dword in the low half
          blk = pend_q[0].addr[9:4];
          dword = store[blk][pend_q[0].addr[3]*dword_width_c +: dword_width_c];
          resp_hdr_o <= pend_q[0];
          resp_data_o <= (pend_q[0].msg_type == e_mem_uc_rd)
                         ? {(block_width_c / dword_width_c){dword}} : store[blk];
          resp_v_o <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_uce.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uce
  import uce_pkg::*;
  ();

  localparam int max_cycles_c = 4000;
  localparam logic [lce_id_width_c-1:0] lce_id_c = 4'h5;

  logic clk = 1'b0;
  logic reset;
  cache_req_t cache_req;
  logic cache_req_v;
  logic cache_req_yumi;
  cache_metadata_t metadata;
  logic metadata_v;
  tag_pkt_t tag_pkt;
  logic tag_pkt_v;
  logic tag_yumi;
  stat_pkt_t stat_pkt;
  logic stat_pkt_v;
  logic stat_yumi;
  data_pkt_t data_pkt;
  logic data_pkt_v;
  logic data_yumi;
  logic yumi_en;
  mem_hdr_t cmd_hdr;
  logic [block_width_c-1:0] cmd_data;
  logic cmd_v;
  logic cmd_ready;
  mem_hdr_t resp_hdr;
  logic [block_width_c-1:0] resp_data;
  logic resp_v;
  logic resp_ready;
  logic busy;
  logic complete;
  logic crit_tag;
  logic crit_data;
  logic credits_full;
  logic credits_empty;
  logic hold_resp;

  cache_req_type_e cur_kind = e_cache_clear;
  mem_hdr_t exp_cmd;
  logic cmd_pending = 1'b0;
  logic [dword_width_c-1:0] exp_store_data;
  tag_pkt_t exp_tag;
  data_pkt_t exp_data;
  int sweep_idx = 0;
  int crit_tag_cnt = 0;
  int crit_data_cnt = 0;
  logic busy_drop_due = 1'b0;
  logic past_first_edge = 1'b0;
  int errors = 0;
  int errors_at_start = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycle = 0;
  logic [paddr_width_c-1:0] addr;
  logic [dword_width_c-1:0] data;

  always #2 clk = ~clk;

  // A yumi is only raised on a valid packet, so it also marks consumption
  assign tag_yumi  = tag_pkt_v & yumi_en;
  assign stat_yumi = stat_pkt_v & yumi_en;
  assign data_yumi = data_pkt_v & yumi_en;

  uce #(.credits_p(4)) dut
  (
    .clk_i (clk), .reset_i (reset), .lce_id_i (lce_id_c),
    .cache_req_i (cache_req), .cache_req_v_i (cache_req_v), .cache_req_yumi_o (cache_req_yumi),
    .cache_metadata_i (metadata), .cache_metadata_v_i (metadata_v),
    .tag_pkt_o (tag_pkt), .tag_pkt_v_o (tag_pkt_v), .tag_pkt_yumi_i (tag_yumi),
    .stat_pkt_o (stat_pkt), .stat_pkt_v_o (stat_pkt_v), .stat_pkt_yumi_i (stat_yumi),
    .data_pkt_o (data_pkt), .data_pkt_v_o (data_pkt_v), .data_pkt_yumi_i (data_yumi),
    .mem_cmd_hdr_o (cmd_hdr), .mem_cmd_data_o (cmd_data), .mem_cmd_v_o (cmd_v),
    .mem_cmd_ready_and_i (cmd_ready),
    .mem_resp_hdr_i (resp_hdr), .mem_resp_data_i (resp_data), .mem_resp_v_i (resp_v),
    .mem_resp_ready_and_o (resp_ready),
    .cache_req_busy_o (busy), .cache_req_complete_o (complete),
    .cache_req_critical_tag_o (crit_tag), .cache_req_critical_data_o (crit_data),
    .cache_req_credits_full_o (credits_full), .cache_req_credits_empty_o (credits_empty)
  );

  tb_mem_responder responder
  (
    .clk_i (clk), .reset_i (reset), .hold_i (hold_resp),
    .cmd_hdr_i (cmd_hdr), .cmd_data_i (cmd_data), .cmd_v_i (cmd_v),
    .cmd_ready_and_o (cmd_ready),
    .resp_hdr_o (resp_hdr), .resp_data_o (resp_data), .resp_v_o (resp_v),
    .resp_ready_and_i (resp_ready)
  );

  task automatic note_error(input string msg);
    errors++;
    $display("error at cycle %0d: %s", cycle, msg);
  endtask

  task automatic note_mismatch(input string name, input logic [159:0] got,
                               input logic [159:0] exp_v);
    errors++;
    $display("FAILED %s got %0h expected %0h (cycle %0d)", name, got, exp_v, cycle);
  endtask

  function automatic logic [block_width_c-1:0] stored_block(input logic [paddr_width_c-1:0] a);
    return responder.store[a[9:4]];
  endfunction

  function automatic logic [dword_width_c-1:0] stored_dword(input logic [paddr_width_c-1:0] a);
    return responder.store[a[9:4]][a[3]*dword_width_c +: dword_width_c];
  endfunction

  task automatic end_test(input string name);
    if (errors == errors_at_start)
    begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: %0d check(s) failed", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // Sets up what the monitor expects, then holds the request until yumi
  task automatic send_req(input cache_req_type_e kind, input logic [paddr_width_c-1:0] a,
                          input logic [dword_width_c-1:0] d, input logic [way_width_c-1:0] way);
    cache_req_t r;
    r.req_type = kind;
    r.addr = a;
    r.size = e_size_8;
    r.data = d;
    cur_kind = kind;
    exp_cmd = '0;
    exp_cmd.lce_id = lce_id_c;
    exp_cmd.addr = a;
    exp_cmd.size = e_size_8;
    exp_cmd.way_id = way;
    exp_data = '0;
    if (kind == e_uc_store)
    begin
      exp_cmd.msg_type = e_mem_uc_wr;
      exp_store_data = d;
    end
    else if (kind == e_uc_load)
    begin
      exp_cmd.msg_type = e_mem_uc_rd;
      exp_data.opcode = e_data_uncached;
      exp_data.data = {(block_width_c / dword_width_c){stored_dword(a)}};
    end
    else if (kind == e_miss_load)
    begin
      exp_cmd.msg_type = e_mem_rd;
      exp_cmd.addr = {a[paddr_width_c-1:block_offset_width_c], {block_offset_width_c{1'b0}}};
      exp_cmd.size = e_size_16;
      exp_tag.opcode = e_tag_set_tag;
      exp_tag.index = a[block_offset_width_c +: index_width_c];
      exp_tag.way_id = way;
      exp_tag.state = e_coh_m;
      exp_tag.tag = a[paddr_width_c-1 -: tag_width_c];
      exp_data.opcode = e_data_write;
      exp_data.index = exp_tag.index;
      exp_data.way_id = way;
      exp_data.data = stored_block(a);
    end
    cmd_pending = (kind != e_cache_clear);
    cache_req = r;
    cache_req_v = 1'b1;
    do
      @(posedge clk);
    while (!cache_req_yumi);
    #0.5;
    cache_req_v = 1'b0;
    if (kind == e_miss_load)
    begin
      metadata.hit_or_repl_way = way;
      metadata_v = 1'b1;
      @(posedge clk);
      #0.5;
      metadata_v = 1'b0;
    end
  endtask

  task automatic wait_complete();
    do
      @(posedge clk);
    while (!complete);
    #0.5;
  endtask

  always @(posedge clk)
  begin
    #0.5;
    yumi_en = ($urandom_range(0, 3) != 0);
  end

  always @(posedge clk)
  begin
    cycle++;
    if (cycle >= max_cycles_c)
    begin
      $display("timeout: run stopped after %0d cycles with requests still open", cycle);
      $display("TEST FAILED");
      $finish;
    end
  end

  always @(posedge clk)
  begin
    if (reset && past_first_edge)
    begin
      assert (busy && !tag_pkt_v && !stat_pkt_v && !data_pkt_v && !cmd_v && !cache_req_yumi
              && !complete && !crit_tag && !crit_data)
        else note_error("outputs not idle during reset");
    end
    else if (!reset)
    begin
      if (busy_drop_due)
        assert (!busy) else note_mismatch("cache_req_busy_o", busy, 0);
      busy_drop_due = 1'b0;
      assert (!credits_full || busy) else note_mismatch("cache_req_busy_o", busy, 1);
      if (tag_yumi && tag_pkt.opcode == e_tag_clear_set)
      begin
        assert (tag_pkt.index == sweep_idx[index_width_c-1:0])
          else note_mismatch("tag_pkt_o.index", tag_pkt.index, sweep_idx);
        assert (stat_yumi) else note_error("status clear not consumed with its tag clear");
        assert (stat_pkt.index == sweep_idx[index_width_c-1:0])
          else note_mismatch("stat_pkt_o.index", stat_pkt.index, sweep_idx);
        assert (busy) else note_error("busy low during the clear sweep");
        sweep_idx++;
      end
      if (tag_yumi && tag_pkt.opcode == e_tag_set_tag)
        assert (tag_pkt == exp_tag) else note_mismatch("tag_pkt_o", tag_pkt, exp_tag);
      if (data_yumi && exp_data.opcode == e_data_write)
        assert (data_pkt == exp_data) else note_mismatch("data_pkt_o", data_pkt, exp_data);
      else if (data_yumi)
        assert (data_pkt.opcode == e_data_uncached && data_pkt.data == exp_data.data)
          else note_mismatch("data_pkt_o.data", data_pkt.data, exp_data.data);
      if (cmd_v && cmd_ready)
      begin
        assert (cmd_pending) else note_error("command sent with no request waiting");
        assert (cmd_hdr.msg_type == exp_cmd.msg_type)
          else note_mismatch("mem_cmd_hdr_o.msg_type", cmd_hdr.msg_type, exp_cmd.msg_type);
        assert (cmd_hdr.addr == exp_cmd.addr)
          else note_mismatch("mem_cmd_hdr_o.addr", cmd_hdr.addr, exp_cmd.addr);
        assert (cmd_hdr.size == exp_cmd.size && cmd_hdr.lce_id == exp_cmd.lce_id)
          else note_mismatch("mem_cmd_hdr_o.size/lce_id", {cmd_hdr.size, cmd_hdr.lce_id},
                             {exp_cmd.size, exp_cmd.lce_id});
        if (exp_cmd.msg_type == e_mem_rd)
          assert (cmd_hdr.way_id == exp_cmd.way_id)
            else note_mismatch("mem_cmd_hdr_o.way_id", cmd_hdr.way_id, exp_cmd.way_id);
        if (exp_cmd.msg_type == e_mem_uc_wr)
        begin
          assert (cmd_data == {(block_width_c / dword_width_c){exp_store_data}})
            else note_mismatch("mem_cmd_data_o", cmd_data, exp_store_data);
          assert (complete) else note_error("store did not complete on its command");
        end
        cmd_pending = 1'b0;
      end
      if (cmd_v)
        assert (!credits_full) else note_error("command valid while credits are full");
      if (crit_tag)
        crit_tag_cnt++;
      if (crit_data)
        crit_data_cnt++;
      if (complete)
      begin
        case (cur_kind)
          e_cache_clear:
          begin
            assert (sweep_idx == sets_c) else note_mismatch("clear packet count", sweep_idx, sets_c);
            sweep_idx = 0;
            busy_drop_due = 1'b1;
          end
          e_uc_store:
            assert (!cmd_pending && crit_tag_cnt == 0 && crit_data_cnt == 0)
              else note_error("store completed without its command or with critical pulses");
          e_uc_load:
            assert (crit_data_cnt == 1 && crit_tag_cnt == 0 && data_yumi)
              else note_error("uncached load completed without one critical data pulse");
          default:
            assert (crit_tag_cnt == 1 && crit_data_cnt == 1 && tag_yumi && data_yumi)
              else note_error("miss load completed without its fill or critical pulses");
        endcase
        crit_tag_cnt = 0;
        crit_data_cnt = 0;
      end
    end
    past_first_edge = 1'b1;
  end

  initial
  begin
    void'($urandom(40981));
    reset = 1'b1;
    cache_req = '0;
    cache_req_v = 1'b0;
    metadata = '0;
    metadata_v = 1'b0;
    yumi_en = 1'b0;
    hold_resp = 1'b0;
    repeat (5) @(posedge clk);
    #0.5;
    reset = 1'b0;

    wait_complete();
    @(posedge clk);
    #0.5;
    end_test("reset clear sweep");

    repeat (6)
    begin
      addr = $urandom & 32'hffff_fff8;
      data = {$urandom, $urandom};
      send_req(e_uc_store, addr, data, '0);
      wait_complete();
      assert (stored_dword(addr) == data)
        else note_mismatch("responder store", stored_dword(addr), data);
    end
    end_test("uncached store");

    repeat (6)
    begin
      send_req(e_uc_load, $urandom & 32'hffff_fff8, '0, '0);
      wait_complete();
    end
    end_test("uncached load");

    repeat (6)
    begin
      send_req(e_miss_load, $urandom, '0, way_width_c'($urandom_range(0, assoc_c - 1)));
      wait_complete();
    end
    end_test("miss load");

    send_req(e_cache_clear, '0, '0, '0);
    wait_complete();
    @(posedge clk);
    #0.5;
    end_test("clear request");

    while (!credits_empty)
      @(posedge clk);
    #0.5;
    hold_resp = 1'b1;
    repeat (4)
    begin
      send_req(e_uc_store, $urandom & 32'hffff_fff8, {$urandom, $urandom}, '0);
      wait_complete();
    end
    assert (credits_full) else note_mismatch("cache_req_credits_full_o", credits_full, 1);
    assert (!credits_empty)
      else note_mismatch("cache_req_credits_empty_o", credits_empty, 0);
    assert (busy) else note_mismatch("cache_req_busy_o", busy, 1);
    addr = $urandom & 32'hffff_fff8;
    data = {$urandom, $urandom};
    send_req(e_uc_store, addr, data, '0);
    // Observation window in which the fifth command must stay blocked
    repeat (20) @(posedge clk);
    #0.5;
    assert (cmd_pending) else note_error("fifth store was sent while credits were full");
    hold_resp = 1'b0;
    wait_complete();
    assert (stored_dword(addr) == data)
      else note_mismatch("responder store", stored_dword(addr), data);
    while (!credits_empty)
      @(posedge clk);
    #0.5;
    end_test("credits");

    $display("tests passed %0d, tests failed %0d, failed checks %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
